//--- dv/seq_stim.txt
// flag nibble followed by the 32-bit instruction word
// flag 1 marks a word that must issue
1_2315_7abc
0_0000_0000
1_1100_0008
1_2a0c_3011
1_1000_0123
1_21ff_ffff
1_1100_0002
1_2400_a001
0_7000_0000
1_1100_0014
1_25ab_c002
1_2612_3456
0_f000_0000
0_2300_0001
0_1100_0004
0_2fff_ffff

//--- dv/seq_tb.sv
// Sequencer front end testbench
`timescale 1ns/1ps
`default_nettype none

module seq_tb;

    import seq_pkg::*;

    localparam int ROWS = 1 << PC_W;

    logic                clk;
    logic                rst_n;
    logic                i_sys_start;
    logic                i_inst_vld;
    inst_t               i_inst;
    logic                o_pc_vld;
    logic [PC_W-1:0]     o_pc;
    logic                o_issue_vld;
    issue_op_t           o_issue;
    logic                o_comp_vld;
    logic [CNT_W-1:0]    o_seq_cnt;
    logic                o_sys_done;

    // flag nibble over the instruction word
    logic [35:0]         rom [ROWS];
    issue_op_t           exp_ops [$];
    logic                req_vld [IRAM_LAT];
    logic [PC_W-1:0]     req_pc [IRAM_LAT];
    logic [SCALAR_W-1:0] vlen_m;
    logic [31:0]         lfsr;
    int                  exp_idx;
    int                  beats_left;
    int                  beat_no;
    int                  since_issue;
    int                  min_gap;
    int                  cycles;
    int                  limit;

    seq_top seq_top_i (
        .clk(clk), .rst_n(rst_n), .i_sys_start(i_sys_start), .i_inst_vld(i_inst_vld),
        .i_inst(i_inst), .o_pc_vld(o_pc_vld), .o_pc(o_pc), .o_issue_vld(o_issue_vld),
        .o_issue(o_issue), .o_comp_vld(o_comp_vld), .o_seq_cnt(o_seq_cnt),
        .o_sys_done(o_sys_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // vector length to beat count with zero raised to one
    function automatic int beats_for(input logic [SCALAR_W-1:0] vlen);
        int n;
        n = int'(vlen) >> LANE_SHIFT;
        return (n == 0) ? 1 : n;
    endfunction

    // only called for cfg and compute words
    function automatic issue_op_t ref_decode(input inst_t w);
        issue_op_t r;
        r = '0;
        if (w.cfg.opcode == OPC_CFG) begin
            r.is_cfg   = 1'b1;
            r.cfg_kind = w.cfg.cfg_kind;
            r.scalar   = w.cfg.scalar;
        end else begin
            r.alu_op = w.comp.alu_op;
            r.rd     = w.comp.rd;
            r.wr     = w.comp.wr;
            r.scalar = w.comp.scalar;
        end
        return r;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic op_compare(input string name, input issue_op_t got, input issue_op_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic count_compare(input string name, input logic [CNT_W-1:0] got,
                                 input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    // instruction RAM answers each request IRAM_LAT cycles later
    always begin
        wait_cycle();
        i_inst_vld = req_vld[IRAM_LAT-1];
        i_inst     = rom[req_pc[IRAM_LAT-1]][31:0];
        for (int k = IRAM_LAT - 1; k > 0; k--) begin
            req_vld[k] = req_vld[k-1];
            req_pc[k]  = req_pc[k-1];
        end
        req_vld[0] = o_pc_vld;
        req_pc[0]  = o_pc;
    end

    ////////////////////
    // output monitor
    ////////////////////
    always begin
        wait_cycle();
        if (rst_n) begin
            cycles++;
            if (cycles > limit) begin
                stop_on_error($sformatf("Timeout, run not finished after %0d cycles", limit));
            end
            since_issue++;
            if (o_issue_vld) begin
                if (exp_idx >= exp_ops.size()) begin
                    stop_on_error("An operation issued that the program does not contain");
                end
                op_compare("o_issue", o_issue, exp_ops[exp_idx]);
                if (since_issue < min_gap) begin
                    stop_on_error($sformatf("Issue only %0d cycles after the previous, %0d needed",
                                            since_issue, min_gap));
                end
                if (exp_ops[exp_idx].is_cfg) begin
                    min_gap = 1 + CFG_SYNC_CYCLES;
                    if (exp_ops[exp_idx].cfg_kind == CFG_VLEN) begin
                        vlen_m = exp_ops[exp_idx].scalar;
                    end
                end else begin
                    beats_left = beats_for(vlen_m);
                    beat_no    = 0;
                    min_gap    = beats_left + SYNC_CYCLES;
                end
                since_issue = 0;
                exp_idx++;
            end
            // beats start in the issue cycle itself
            flag_compare("o_comp_vld", o_comp_vld, beats_left > 0);
            if (beats_left > 0) begin
                count_compare("o_seq_cnt", o_seq_cnt, CNT_W'(beat_no));
                beat_no++;
                beats_left--;
            end
            if (o_sys_done) begin
                flag_compare("o_pc_vld", o_pc_vld, 1'b0);
            end
        end
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        inst_t               w;
        logic [3:0]          delay;
        logic [SCALAR_W-1:0] scan_vlen;
        logic                must_issue;
        bit                  past_brk;
        int                  budget;

        rst_n       = 1'b0;
        i_sys_start = 1'b0;
        i_inst_vld  = 1'b0;
        i_inst      = '0;
        foreach (req_vld[k]) begin
            req_vld[k] = 1'b0;
            req_pc[k]  = '0;
        end
        // compute words carrying their own address beyond the program
        foreach (rom[a]) begin
            rom[a] = {4'h0, 8'h25, 16'h0000, 8'(a)};
        end
        $readmemh("dv/seq_stim.txt", rom);
        vlen_m    = SCALAR_W'(VLEN_RESET);
        scan_vlen = SCALAR_W'(VLEN_RESET);
        lfsr      = 32'hfab5_3238;
        budget    = IQ_DEPTH + IRAM_LAT;
        past_brk  = 1'b0;

        // expected issues and cycle budget from the program image
        foreach (rom[a]) begin
            w = rom[a][31:0];
            must_issue = !past_brk && (w.cfg.opcode inside {OPC_CFG, OPC_COMP});
            if (rom[a][32] !== must_issue) begin
                stop_on_error($sformatf("Stimulus row %0d has a flag that disagrees with its opcode", a));
            end
            if (w.cfg.opcode == OPC_BRK) begin
                past_brk = 1'b1;
            end
            if (must_issue) begin
                exp_ops.push_back(ref_decode(w));
                if (w.cfg.opcode == OPC_CFG) begin
                    budget += 1 + CFG_SYNC_CYCLES;
                    if (w.cfg.cfg_kind == CFG_VLEN) begin
                        scan_vlen = w.cfg.scalar;
                    end
                end else begin
                    budget += beats_for(scan_vlen) + SYNC_CYCLES;
                end
            end else if (!past_brk) begin
                budget += 1;
            end
        end
        limit = 2 * budget + 200;

        repeat (5) wait_cycle();
        rst_n = 1'b1;
        wait_cycle();
        flag_compare("o_pc_vld", o_pc_vld, 1'b0);
        flag_compare("o_issue_vld", o_issue_vld, 1'b0);
        flag_compare("o_comp_vld", o_comp_vld, 1'b0);
        flag_compare("o_sys_done", o_sys_done, 1'b0);

        for (int run = 0; run < 2; run++) begin
            if (run == 1) begin
                delay = '0;
                repeat (4) begin
                    lfsr  = lfsr_next(lfsr);
                    delay = {delay[2:0], lfsr[0]};
                end
                repeat (int'(delay) + 1) wait_cycle();
            end
            exp_idx     = 0;
            i_sys_start = 1'b1;
            wait_cycle();
            i_sys_start = 1'b0;
            flag_compare("o_pc_vld", o_pc_vld, 1'b1);
            count_compare("o_pc", CNT_W'(o_pc), '0);
            flag_compare("o_sys_done", o_sys_done, 1'b0);
            while (!o_sys_done) begin
                wait_cycle();
            end
            if (exp_idx != exp_ops.size()) begin
                stop_on_error($sformatf("Done rose after %0d of %0d issues in run %0d",
                                        exp_idx, exp_ops.size(), run));
            end
            // idle window where nothing may issue or fetch
            repeat (8) wait_cycle();
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/seq_decode.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module seq_decode (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                i_en,
    input  wire                i_flush,
    input  wire seq_pkg::inst_t i_inst,
    output logic               o_push,
    output seq_pkg::issue_op_t o_op,
    output logic               o_break
);

    import seq_pkg::*;

    opcode_t   opcode;
    issue_op_t op_dec;
    logic      discard;

    // opcode first, then the matching view of the word
    always_comb begin
        opcode = i_inst.cfg.opcode;
        op_dec = '0;
        case (opcode)
            OPC_CFG: begin
                op_dec.is_cfg   = 1'b1;
                op_dec.cfg_kind = i_inst.cfg.cfg_kind;
                op_dec.scalar   = i_inst.cfg.scalar;
            end
            OPC_COMP: begin
                op_dec.cfg_kind = CFG_NONE;
                op_dec.alu_op   = i_inst.comp.alu_op;
                op_dec.rd       = i_inst.comp.rd;
                op_dec.wr       = i_inst.comp.wr;
                op_dec.scalar   = i_inst.comp.scalar;
            end
            default: op_dec = '0;
        endcase
    end

    // fetch sees the break one cycle late, so the break pulse itself also discards
    assign discard = i_flush || o_break;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_push  <= 1'b0;
            o_break <= 1'b0;
        end else begin
            o_push  <= i_en && !discard && (opcode == OPC_CFG || opcode == OPC_COMP);
            o_break <= i_en && !discard && (opcode == OPC_BRK);
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_op <= op_dec;
        end
    end

endmodule

`default_nettype wire

//--- logic/seq_fetch.sv
// Instruction fetch FSM
`timescale 1ns/1ps
`default_nettype none

module seq_fetch #(
    parameter int PC_W = 8
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             i_sys_start,
    input  wire             i_break,
    input  wire             i_iq_afull,
    input  wire             i_iq_empty,
    output logic            o_pc_vld,
    output logic [PC_W-1:0] o_pc,
    output logic            o_flush,
    output logic            o_halted
);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_INCR,
        ST_HOLD,
        ST_DRAIN
    } state_t;

    state_t state_q;
    state_t state_nxt;
    logic   halted_q;

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_RESET: begin
                if (i_sys_start) begin
                    state_nxt = ST_INCR;
                end
            end
            ST_INCR: begin
                if (i_break) begin
                    state_nxt = ST_DRAIN;
                end else if (i_iq_afull) begin
                    state_nxt = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (i_break) begin
                    state_nxt = ST_DRAIN;
                end else if (!i_iq_afull) begin
                    state_nxt = ST_INCR;
                end
            end
            ST_DRAIN: begin
                if (i_iq_empty) begin
                    state_nxt = ST_RESET;
                end
            end
            default: state_nxt = ST_RESET;
        endcase
    end

    // pc parks at all ones so the first request is 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_RESET;
            o_pc_vld <= 1'b0;
            o_pc     <= '1;
            halted_q <= 1'b0;
        end else begin
            state_q  <= state_nxt;
            o_pc_vld <= (state_nxt == ST_INCR);
            if (state_nxt == ST_INCR) begin
                o_pc <= o_pc + 1'b1;
            end else if (state_nxt == ST_RESET || state_nxt == ST_DRAIN) begin
                o_pc <= '1;
            end
            if (i_sys_start) begin
                halted_q <= 1'b0;
            end else if (state_q == ST_DRAIN && state_nxt == ST_RESET) begin
                halted_q <= 1'b1;
            end
        end
    end

    // words still in flight can land after the drain and are dropped as well
    assign o_flush  = (state_q == ST_DRAIN) || halted_q;
    assign o_halted = halted_q;

    a_no_fetch_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        o_flush |-> !o_pc_vld);

endmodule

`default_nettype wire

//--- logic/seq_fifo.sv
// First-word-fall-through queue
`timescale 1ns/1ps
`default_nettype none

module seq_fifo #(
    parameter int DEPTH        = 8,
    parameter int WIDTH        = 32,
    parameter int AFULL_MARGIN = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              i_push,
    input  wire  [WIDTH-1:0] i_data,
    input  wire              i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_afull
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;

    // wrap at DEPTH, not only at powers of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (i_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({i_push, i_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

    // head word visible without a read cycle
    assign o_data  = mem[rd_ptr_q];
    assign o_empty = (count_q == '0);
    assign o_afull = (DEPTH - int'(count_q)) <= AFULL_MARGIN;

    // upstream flow control must keep these from happening
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        count_q == CW'(DEPTH) |-> !i_push);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        o_empty |-> !i_pop);

endmodule

`default_nettype wire

//--- logic/seq_issue.sv
// Issue controller
`timescale 1ns/1ps
`default_nettype none

module seq_issue #(
    parameter int CNT_W           = 10,
    parameter int LANE_SHIFT      = 2,
    parameter int SYNC_CYCLES     = 2,
    parameter int CFG_SYNC_CYCLES = 3,
    parameter int VLEN_RESET      = 16
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_sys_start,
    input  wire                    i_halted,
    input  wire                    i_opq_empty,
    input  wire seq_pkg::issue_op_t i_head,
    output logic                   o_pop,
    output logic                   o_issue_vld,
    output seq_pkg::issue_op_t     o_issue,
    output logic                   o_comp_vld,
    output logic [CNT_W-1:0]       o_seq_cnt,
    output logic                   o_sys_done
);

    import seq_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONFIG,
        ST_EMIT,
        ST_WAIT,
        ST_SYNC,
        ST_CFG_SYNC
    } state_t;

    state_t              state_q;
    state_t              state_nxt;
    state_t              start_st;
    logic [CNT_W-1:0]    cnt_q;
    logic [CNT_W-1:0]    cnt_nxt;
    logic [CNT_W-1:0]    beats_q;
    logic [CNT_W-1:0]    beats_calc;
    logic [SCALAR_W-1:0] vlen_q;
    logic [SCALAR_W-1:0] vlen_shift;

    // beats per op with a floor of one
    assign vlen_shift = vlen_q >> LANE_SHIFT;
    assign beats_calc = (vlen_shift == '0) ? CNT_W'(1) : CNT_W'(vlen_shift);

    // where to go when ready for the next op
    always_comb begin
        if (i_opq_empty) begin
            start_st = ST_IDLE;
        end else if (i_head.is_cfg) begin
            start_st = ST_CONFIG;
        end else begin
            start_st = ST_EMIT;
        end
    end

    ////////////////////
    // next state and counter
    ////////////////////
    always_comb begin
        state_nxt = state_q;
        cnt_nxt   = '0;
        case (state_q)
            ST_IDLE:   state_nxt = start_st;
            ST_CONFIG: state_nxt = ST_CFG_SYNC;
            ST_EMIT: begin
                if (beats_calc == CNT_W'(1)) begin
                    state_nxt = ST_SYNC;
                end else begin
                    state_nxt = ST_WAIT;
                    cnt_nxt   = CNT_W'(1);
                end
            end
            ST_WAIT: begin
                if (cnt_q == beats_q - 1'b1) begin
                    state_nxt = ST_SYNC;
                end else begin
                    cnt_nxt = cnt_q + 1'b1;
                end
            end
            // the same counter times both sync gaps
            ST_SYNC: begin
                if (cnt_q == CNT_W'(SYNC_CYCLES - 1)) begin
                    state_nxt = start_st;
                end else begin
                    cnt_nxt = cnt_q + 1'b1;
                end
            end
            ST_CFG_SYNC: begin
                if (cnt_q == CNT_W'(CFG_SYNC_CYCLES - 1)) begin
                    state_nxt = start_st;
                end else begin
                    cnt_nxt = cnt_q + 1'b1;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // vlen survives a restart
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            vlen_q     <= SCALAR_W'(VLEN_RESET);
            o_sys_done <= 1'b0;
        end else begin
            state_q <= state_nxt;
            cnt_q   <= cnt_nxt;
            if (state_q == ST_CONFIG && i_head.cfg_kind == CFG_VLEN) begin
                vlen_q <= i_head.scalar;
            end
            if (i_sys_start) begin
                o_sys_done <= 1'b0;
            end else if (i_halted && i_opq_empty && state_q == ST_IDLE) begin
                o_sys_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_EMIT) begin
            beats_q <= beats_calc;
        end
    end

    assign o_issue_vld = (state_q == ST_CONFIG) || (state_q == ST_EMIT);
    assign o_pop       = o_issue_vld;
    assign o_issue     = i_head;
    assign o_comp_vld  = (state_q == ST_EMIT) || (state_q == ST_WAIT);
    assign o_seq_cnt   = cnt_q;

    // the op queue head must hold a real entry when issued
    a_issue_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        o_issue_vld |-> !i_opq_empty);

endmodule

`default_nettype wire

//--- logic/seq_pkg.sv
// Sequencer shared definitions
`default_nettype none

package seq_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int INST_W   = 32;
    localparam int SCALAR_W = 12;
    localparam int CNT_W    = 10;
    localparam int PC_W     = 8;

    // defaults handed down by the top level
    localparam int IQ_DEPTH        = 8;
    localparam int OPQ_DEPTH       = 4;
    localparam int IRAM_LAT        = 1;
    localparam int LANE_SHIFT      = 2;
    localparam int SYNC_CYCLES     = 2;
    localparam int CFG_SYNC_CYCLES = 3;
    localparam int VLEN_RESET      = 16;

    ////////////////////
    // encodings
    ////////////////////
    // unlisted opcodes decode as nop
    typedef enum logic [3:0] {
        OPC_NOP  = 4'h0,
        OPC_CFG  = 4'h1,
        OPC_COMP = 4'h2,
        OPC_BRK  = 4'hf
    } opcode_t;

    typedef enum logic [3:0] {
        CFG_NONE = 4'h0,
        CFG_VLEN = 4'h1
    } cfg_kind_t;

    // bank address plus enable
    typedef struct packed {
        logic [4:0] addr;
        logic       en;
    } rw_op_t;

    // opcode sits in the same bits in both views
    typedef union packed {
        struct packed {
            opcode_t             opcode;
            cfg_kind_t           cfg_kind;
            logic [11:0]         rsvd;
            logic [SCALAR_W-1:0] scalar;
        } cfg;
        struct packed {
            opcode_t             opcode;
            logic [3:0]          alu_op;
            rw_op_t              rd;
            rw_op_t              wr;
            logic [SCALAR_W-1:0] scalar;
        } comp;
    } inst_t;

    // operation queue payload and issue bundle
    typedef struct packed {
        logic                is_cfg;
        cfg_kind_t           cfg_kind;
        logic [3:0]          alu_op;
        rw_op_t              rd;
        rw_op_t              wr;
        logic [SCALAR_W-1:0] scalar;
    } issue_op_t;

endpackage

`default_nettype wire

//--- logic/seq_top.sv
// Sequencer front end
`timescale 1ns/1ps
`default_nettype none

module seq_top #(
    parameter int IQ_DEPTH        = seq_pkg::IQ_DEPTH,
    parameter int OPQ_DEPTH       = seq_pkg::OPQ_DEPTH,
    parameter int IRAM_LAT        = seq_pkg::IRAM_LAT,
    parameter int LANE_SHIFT      = seq_pkg::LANE_SHIFT,
    parameter int SYNC_CYCLES     = seq_pkg::SYNC_CYCLES,
    parameter int CFG_SYNC_CYCLES = seq_pkg::CFG_SYNC_CYCLES,
    parameter int VLEN_RESET      = seq_pkg::VLEN_RESET
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_sys_start,
    input  wire                       i_inst_vld,
    input  wire seq_pkg::inst_t       i_inst,
    output logic                      o_pc_vld,
    output logic [seq_pkg::PC_W-1:0]  o_pc,
    output logic                      o_issue_vld,
    output seq_pkg::issue_op_t        o_issue,
    output logic                      o_comp_vld,
    output logic [seq_pkg::CNT_W-1:0] o_seq_cnt,
    output logic                      o_sys_done
);

    import seq_pkg::*;

    logic      iq_empty;
    logic      iq_afull;
    inst_t     iq_head;
    logic      flush;
    logic      halted;
    logic      dec_push;
    issue_op_t dec_op;
    logic      dec_break;
    logic      opq_empty;
    logic      opq_afull;
    issue_op_t opq_head;
    logic      opq_pop;

    // decode only while the op queue has room for the word in flight
    wire iq_pop = !iq_empty && !opq_afull;

    ////////////////////
    // fetch and queues
    ////////////////////
    seq_fetch #(.PC_W(PC_W)) fetch_i (
        .clk(clk), .rst_n(rst_n), .i_sys_start(i_sys_start), .i_break(dec_break),
        .i_iq_afull(iq_afull), .i_iq_empty(iq_empty), .o_pc_vld(o_pc_vld),
        .o_pc(o_pc), .o_flush(flush), .o_halted(halted)
    );

    // room for every word still coming back from the RAM
    seq_fifo #(.DEPTH(IQ_DEPTH), .WIDTH($bits(inst_t)), .AFULL_MARGIN(IRAM_LAT + 1)) inst_queue (
        .clk(clk), .rst_n(rst_n), .i_push(i_inst_vld), .i_data(i_inst), .i_pop(iq_pop),
        .o_data(iq_head), .o_empty(iq_empty), .o_afull(iq_afull)
    );

    seq_decode decode_i (
        .clk(clk), .rst_n(rst_n), .i_en(iq_pop), .i_flush(flush), .i_inst(iq_head),
        .o_push(dec_push), .o_op(dec_op), .o_break(dec_break)
    );

    seq_fifo #(.DEPTH(OPQ_DEPTH), .WIDTH($bits(issue_op_t)), .AFULL_MARGIN(1)) op_queue (
        .clk(clk), .rst_n(rst_n), .i_push(dec_push), .i_data(dec_op), .i_pop(opq_pop),
        .o_data(opq_head), .o_empty(opq_empty), .o_afull(opq_afull)
    );

    seq_issue #(
        .CNT_W(CNT_W), .LANE_SHIFT(LANE_SHIFT), .SYNC_CYCLES(SYNC_CYCLES),
        .CFG_SYNC_CYCLES(CFG_SYNC_CYCLES), .VLEN_RESET(VLEN_RESET)
    ) issue_i (
        .clk(clk), .rst_n(rst_n), .i_sys_start(i_sys_start), .i_halted(halted),
        .i_opq_empty(opq_empty), .i_head(opq_head), .o_pop(opq_pop),
        .o_issue_vld(o_issue_vld), .o_issue(o_issue), .o_comp_vld(o_comp_vld),
        .o_seq_cnt(o_seq_cnt), .o_sys_done(o_sys_done)
    );

endmodule

`default_nettype wire

//--- src.f
logic/seq_pkg.sv
logic/seq_fifo.sv
logic/seq_fetch.sv
logic/seq_decode.sv
logic/seq_issue.sv
logic/seq_top.sv
dv/seq_tb.sv
